// File: rtl/pulse_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_sequencer (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire                                  seq_en,
	input  wire  [timetag_pkg::NUM_CHANNELS-1:0] chan_mask,
	input  wire  [timetag_pkg::COUNT_WIDTH-1:0]  low_count,
	input  wire  [timetag_pkg::COUNT_WIDTH-1:0]  high_count,
	output logic [timetag_pkg::NUM_CHANNELS-1:0] laser_en
);

	import timetag_pkg::*;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_HIGH,
		SEQ_LOW
	} seq_state_t;

	seq_state_t             state;
	logic [COUNT_WIDTH-1:0] cnt;         // cycles left in phase, minus one
	logic [COUNT_WIDTH-1:0] high_load;
	logic [COUNT_WIDTH-1:0] low_load;

	// a programmed 0 behaves like 1
	assign high_load = (high_count == '0) ? '0 : high_count - 1'b1;
	assign low_load  = (low_count == '0) ? '0 : low_count - 1'b1;

	// ========================================
	// phase fsm
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= SEQ_IDLE;
			cnt   <= '0;
		end else if (!seq_en) begin
			state <= SEQ_IDLE;   // enables drop on the next cycle
			cnt   <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					state <= SEQ_HIGH;
					cnt   <= high_load;
				end
				SEQ_HIGH: begin
					if (cnt == '0) begin
						state <= SEQ_LOW;
						cnt   <= low_load;
					end else
						cnt <= cnt - 1'b1;
				end
				SEQ_LOW: begin
					if (cnt == '0) begin
						state <= SEQ_HIGH;
						cnt   <= high_load;
					end else
						cnt <= cnt - 1'b1;
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	assign laser_en = {NUM_CHANNELS{state == SEQ_HIGH}} & chan_mask;

endmodule

`default_nettype wire

// File: rtl/tag_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tag_capture (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire  [timetag_pkg::NUM_CHANNELS-1:0] detectors,
	input  wire                                  det_en,
	input  wire  [timetag_pkg::TS_WIDTH-1:0]     timestamp,
	output logic                                 tag_valid,
	output timetag_pkg::tag_t                    tag
);

	import timetag_pkg::*;

	logic [NUM_CHANNELS-1:0] sync_q1;    // first synchronizer stage
	logic [NUM_CHANNELS-1:0] sync_q2;
	logic [NUM_CHANNELS-1:0] prev_q;     // sync_q2 one cycle late
	logic [NUM_CHANNELS-1:0] rise;

	// detectors are asynchronous to clk
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			prev_q  <= '0;
		end else begin
			sync_q1 <= detectors;
			sync_q2 <= sync_q1;
			prev_q  <= sync_q2;
		end
	end

	assign rise = sync_q2 & ~prev_q;

	// one tag per cycle, several channels share it
	always_ff @(posedge clk) begin
		if (!rst_n)
			tag_valid <= 1'b0;
		else
			tag_valid <= det_en & (|rise);
	end

	always_ff @(posedge clk) begin
		if (det_en && (|rise)) begin
			tag.mask <= rise;
			tag.ts   <= timestamp;   // stamp of the detection cycle itself
		end
	end

endmodule

`default_nettype wire

// File: rtl/tag_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tag_fifo (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire                                 push,
	input  wire  timetag_pkg::tag_t             din,
	input  wire                                 pop,
	input  wire                                 overflow_clear,
	output timetag_pkg::tag_t                   head,
	output logic                                empty,
	output logic [timetag_pkg::LEVEL_WIDTH-1:0] level,
	output logic                                overflow
);

	import timetag_pkg::*;

	tag_t                            mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
	logic [LEVEL_WIDTH-1:0]          count;
	logic                            full;
	logic                            do_push;
	logic                            do_pop;

	assign full    = (count == LEVEL_WIDTH'(FIFO_DEPTH));
	assign empty   = (count == '0);
	assign level   = count;
	assign do_push = push & ~full;      // full fifo drops the new tag
	assign do_pop  = pop & ~empty;
	assign head    = mem[rd_ptr];       // show-ahead

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	// ========================================
	// pointers and fill level
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// sticky until cleared, a new drop wins over the clear
	always_ff @(posedge clk) begin
		if (!rst_n)
			overflow <= 1'b0;
		else if (push && full)
			overflow <= 1'b1;
		else if (overflow_clear)
			overflow <= 1'b0;
	end

endmodule

`default_nettype wire

// File: rtl/timetag_pkg.sv
`default_nettype none

package timetag_pkg;

	// ========================================
	// sizes
	// ========================================
	localparam int NUM_CHANNELS   = 4;     // detector and laser channels
	localparam int TS_WIDTH       = 28;    // free-running timestamp
	localparam int FIFO_DEPTH     = 16;    // tag entries
	localparam int LEVEL_WIDTH    = 5;     // fill level, must hold FIFO_DEPTH itself
	localparam int APB_ADDR_WIDTH = 8;
	localparam int COUNT_WIDTH    = 16;    // sequencer high/low counts

	// ========================================
	// register map
	// ========================================
	localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL     = 8'h00;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_SEQ_LOW  = 8'h04;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_SEQ_HIGH = 8'h08;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS   = 8'h0C;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_TAG      = 8'h10;  // read pops the head
	localparam logic [APB_ADDR_WIDTH-1:0] REG_TIME     = 8'h14;

	// one detection event
	// upper bits are the channel mask, the rest is the timestamp
	typedef struct packed {
		logic [NUM_CHANNELS-1:0] mask;
		logic [TS_WIDTH-1:0]     ts;
	} tag_t;

endpackage

`default_nettype wire

// File: rtl/timetag_regs.sv
`timescale 1ns/1ps
`default_nettype none

module timetag_regs (
	input  wire                                    clk,
	input  wire                                    rst_n,
	// apb slave
	input  wire                                    psel,
	input  wire                                    penable,
	input  wire                                    pwrite,
	input  wire  [timetag_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input  wire  [31:0]                            pwdata,
	output logic [31:0]                            prdata,
	output logic                                   pready,
	output logic                                   pslverr,
	// fifo side
	input  wire  timetag_pkg::tag_t                head,
	input  wire                                    empty,
	input  wire  [timetag_pkg::LEVEL_WIDTH-1:0]    level,
	input  wire                                    overflow,
	output logic                                   pop,
	output logic                                   overflow_clear,
	// control outputs
	output logic                                   det_en,
	output logic                                   seq_en,
	output logic [timetag_pkg::NUM_CHANNELS-1:0]   chan_mask,
	output logic [timetag_pkg::COUNT_WIDTH-1:0]    low_count,
	output logic [timetag_pkg::COUNT_WIDTH-1:0]    high_count,
	output logic [timetag_pkg::TS_WIDTH-1:0]       timestamp
);

	import timetag_pkg::*;

	logic        access;
	logic        wr_en;
	logic        rd_en;
	logic        addr_hit;
	logic [31:0] rd_data;

	// no wait states, so every access cycle completes
	assign access = psel & penable;
	assign wr_en  = access & pwrite;
	assign rd_en  = access & ~pwrite;

	assign pready  = access;
	assign pslverr = access & ~addr_hit;
	assign prdata  = rd_en ? rd_data : '0;

	// tag read pops only when there is something to return
	assign pop = rd_en & (paddr == REG_TAG) & ~empty;
	assign overflow_clear = wr_en & (paddr == REG_STATUS) & pwdata[1];

	// ========================================
	// address decode and read mux
	// ========================================
	always_comb begin
		addr_hit = 1'b1;
		rd_data  = '0;
		case (paddr)
			REG_CTRL: begin
				rd_data[0] = det_en;
				rd_data[1] = seq_en;
				rd_data[4 +: NUM_CHANNELS] = chan_mask;   // laser mask at 7:4
			end
			REG_SEQ_LOW:  rd_data[COUNT_WIDTH-1:0] = low_count;
			REG_SEQ_HIGH: rd_data[COUNT_WIDTH-1:0] = high_count;
			REG_STATUS: begin
				rd_data[0] = empty;
				rd_data[1] = overflow;
				rd_data[8 +: LEVEL_WIDTH] = level;        // fill level at 12:8
			end
			REG_TAG: begin
				if (!empty)
					rd_data = head;   // empty fifo reads as zero
			end
			REG_TIME: rd_data[TS_WIDTH-1:0] = timestamp;
			default:  addr_hit = 1'b0;
		endcase
	end

	// ========================================
	// control and count registers
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			det_en     <= 1'b0;
			seq_en     <= 1'b0;
			chan_mask  <= '0;
			low_count  <= COUNT_WIDTH'(1);
			high_count <= COUNT_WIDTH'(1);
		end else if (wr_en) begin
			case (paddr)
				REG_CTRL: begin
					det_en    <= pwdata[0];
					seq_en    <= pwdata[1];
					chan_mask <= pwdata[4 +: NUM_CHANNELS];
				end
				REG_SEQ_LOW:  low_count  <= pwdata[COUNT_WIDTH-1:0];
				REG_SEQ_HIGH: high_count <= pwdata[COUNT_WIDTH-1:0];
				default: ;    // status clear handled by the fifo, others read only
			endcase
		end
	end

	// free-running timestamp, wraps at TS_WIDTH bits
	always_ff @(posedge clk) begin
		if (!rst_n)
			timestamp <= '0;
		else
			timestamp <= timestamp + 1'b1;
	end

endmodule

`default_nettype wire

// File: rtl/timetag_top.sv
`timescale 1ns/1ps
`default_nettype none

module timetag_top (
	input  wire                                    clk,
	input  wire                                    rst_n,
	// apb slave
	input  wire                                    psel,
	input  wire                                    penable,
	input  wire                                    pwrite,
	input  wire  [timetag_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input  wire  [31:0]                            pwdata,
	output wire  [31:0]                            prdata,
	output wire                                    pready,
	output wire                                    pslverr,
	// photon side
	input  wire  [timetag_pkg::NUM_CHANNELS-1:0]   detectors,
	output wire  [timetag_pkg::NUM_CHANNELS-1:0]   laser_en,
	output wire                                    running
);

	import timetag_pkg::*;

	// ========================================
	// block interconnect
	// ========================================
	wire                    det_en;
	wire                    seq_en;
	wire [NUM_CHANNELS-1:0] chan_mask;
	wire [COUNT_WIDTH-1:0]  low_count;
	wire [COUNT_WIDTH-1:0]  high_count;
	wire [TS_WIDTH-1:0]     timestamp;
	wire                    tag_valid;
	tag_t                   tag;
	tag_t                   head;
	wire                    empty;
	wire [LEVEL_WIDTH-1:0]  level;
	wire                    overflow;
	wire                    pop;
	wire                    overflow_clear;

	assign running = det_en;   // detection enabled

	timetag_regs i_timetag_regs (
		.clk            (clk),
		.rst_n          (rst_n),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.head           (head),
		.empty          (empty),
		.level          (level),
		.overflow       (overflow),
		.pop            (pop),
		.overflow_clear (overflow_clear),
		.det_en         (det_en),
		.seq_en         (seq_en),
		.chan_mask      (chan_mask),
		.low_count      (low_count),
		.high_count     (high_count),
		.timestamp      (timestamp)
	);

	tag_capture i_tag_capture (
		.clk       (clk),
		.rst_n     (rst_n),
		.detectors (detectors),
		.det_en    (det_en),
		.timestamp (timestamp),
		.tag_valid (tag_valid),
		.tag       (tag)
	);

	tag_fifo i_tag_fifo (
		.clk            (clk),
		.rst_n          (rst_n),
		.push           (tag_valid),
		.din            (tag),
		.pop            (pop),
		.overflow_clear (overflow_clear),
		.head           (head),
		.empty          (empty),
		.level          (level),
		.overflow       (overflow)
	);

	pulse_sequencer i_pulse_sequencer (
		.clk        (clk),
		.rst_n      (rst_n),
		.seq_en     (seq_en),
		.chan_mask  (chan_mask),
		.low_count  (low_count),
		.high_count (high_count),
		.laser_en   (laser_en)
	);

endmodule

`default_nettype wire

// File: timetag.f
rtl/timetag_pkg.sv
rtl/timetag_regs.sv
rtl/tag_capture.sv
rtl/tag_fifo.sv
rtl/pulse_sequencer.sv
rtl/timetag_top.sv
verif/timetag_tb.sv

// File: verif/timetag_tb.sv
`timescale 1ns/1ps
`default_nettype none

module timetag_tb;

	import timetag_pkg::*;

	localparam int SPACING_TAGS = 8;   // tags in the random spacing test

	logic                      clk;
	logic                      rst_n;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [APB_ADDR_WIDTH-1:0] paddr;
	logic [31:0]               pwdata;
	logic [31:0]               prdata;
	logic                      pready;
	logic                      pslverr;
	logic [NUM_CHANNELS-1:0]   detectors;
	logic [NUM_CHANNELS-1:0]   laser_en;
	logic                      running;

	timetag_top i_timetag_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.detectors (detectors),
		.laser_en  (laser_en),
		.running   (running)
	);

	always #20 clk = ~clk;   // 40 ns period

	// ========================================
	// failure reporting and compares
	// ========================================
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_tag(input string name, input tag_t exp, input tag_t act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected mask %h ts %h actual mask %h ts %h",
				name, exp.mask, exp.ts, act.mask, act.ts));
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
	endtask

	// ========================================
	// stimulus helpers and apb
	// ========================================
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic apb_transfer(input logic wr, input logic [APB_ADDR_WIDTH-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		step();
		psel    = 1'b1;   // setup cycle
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		step();
		penable = 1'b1;
		waits   = 0;
		@(negedge clk);
		while (pready !== 1'b1) begin
			if (waits >= 8)
				abort_run("APB slave never raised pready");
			waits++;
			@(negedge clk);
		end
		rdata = prdata;   // mid access cycle
		err   = pslverr;
		step();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		logic        err;
		apb_transfer(1'b1, addr, data, unused, err);
		check_bit($sformatf("pslverr on write to %h", addr), 1'b0, err);
	endtask

	task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
		logic err;
		apb_transfer(1'b0, addr, '0, data, err);
		check_bit($sformatf("pslverr on read of %h", addr), 1'b0, err);
	endtask

	// poll status until the fill level matches
	task automatic wait_level(input string name, input int lvl);
		logic [31:0] st;
		int          polls;
		polls = 0;
		apb_read(REG_STATUS, st);
		while (st[12:8] != lvl) begin
			if (polls >= 40)
				abort_run($sformatf("%s: FIFO level never reached %0d", name, lvl));
			polls++;
			apb_read(REG_STATUS, st);
		end
	endtask

	// counts the negedge samples in which lane 0 holds value
	task automatic count_run(input string name, input logic value, output int run);
		run = 0;
		while (laser_en[0] === value) begin
			check_word({name, " laser_en"}, value ? 32'h5 : 32'h0, 32'(laser_en));
			if (run >= 100)
				abort_run($sformatf("%s: laser_en stuck at %b", name, value));
			run++;
			@(negedge clk);
		end
	endtask

	task automatic check_seq_pattern(input string name, input int high, input int low, input int reps);
		int run;
		@(negedge clk);
		count_run(name, 1'b1, run);   // skip a partial high phase
		count_run(name, 1'b0, run);
		for (int r = 0; r < reps; r++) begin
			count_run(name, 1'b1, run);
			check_word({name, " high cycles"}, high, run);
			count_run(name, 1'b0, run);
			check_word({name, " low cycles"}, low, run);
		end
	endtask

	// ========================================
	// directed tests
	// ========================================
	task automatic test_reset_regs();
		logic [31:0] word;
		logic        err;
		check_word("reset laser_en", 32'h0, 32'(laser_en));
		check_bit("reset running", 1'b0, running);
		apb_read(REG_STATUS, word);
		check_word("reset status", 32'h1, word);
		apb_read(REG_SEQ_LOW, word);
		check_word("reset low count", 32'h1, word);
		apb_read(REG_SEQ_HIGH, word);
		check_word("reset high count", 32'h1, word);
		apb_write(REG_CTRL, 32'hA0);    // mask only, nothing enabled
		apb_read(REG_CTRL, word);
		check_word("ctrl readback", 32'hA0, word);
		apb_write(REG_SEQ_LOW, 32'h1234);
		apb_read(REG_SEQ_LOW, word);
		check_word("low count readback", 32'h1234, word);
		apb_write(REG_SEQ_HIGH, 32'hBEEF);
		apb_read(REG_SEQ_HIGH, word);
		check_word("high count readback", 32'hBEEF, word);
		apb_transfer(1'b0, 8'h20, '0, word, err);
		check_bit("unmapped read pslverr", 1'b1, err);
		check_word("unmapped read data", 32'h0, word);
		apb_transfer(1'b1, 8'h20, 32'hFFFF_FFFF, word, err);
		check_bit("unmapped write pslverr", 1'b1, err);
		apb_write(REG_CTRL, 32'h0);
	endtask

	task automatic test_tag_spacing();
		int          chan [SPACING_TAGS];
		int          space [SPACING_TAGS];
		logic [31:0] word;
		tag_t        t;
		tag_t        prev;
		tag_t        exp;
		apb_write(REG_CTRL, 32'h1);
		for (int i = 0; i < SPACING_TAGS; i++) begin
			chan[i]  = $urandom % NUM_CHANNELS;
			space[i] = 5 + $urandom % 36;
			step();
			detectors = NUM_CHANNELS'(1 << chan[i]);
			step();
			detectors = '0;
			repeat (space[i] - 2) step();   // next rising input space[i] cycles later
		end
		wait_level("tag spacing", SPACING_TAGS);
		for (int i = 0; i < SPACING_TAGS; i++) begin
			apb_read(REG_TAG, word);
			t = word;
			if (i == 0) begin
				check_word("tag spacing first mask", 32'(1 << chan[0]), 32'(t.mask));
			end else begin
				exp.mask = NUM_CHANNELS'(1 << chan[i]);
				exp.ts   = prev.ts + TS_WIDTH'(space[i-1]);
				check_tag($sformatf("tag spacing tag %0d", i), exp, t);
			end
			prev = t;
		end
		apb_read(REG_STATUS, word);
		check_word("tag spacing final status", 32'h1, word);
	endtask

	task automatic test_simultaneous_disable();
		logic [31:0] word;
		tag_t        t;
		apb_write(REG_CTRL, 32'h1);
		check_bit("running with det_en", 1'b1, running);
		step();
		detectors = 4'b1010;
		step();
		detectors = '0;
		wait_level("simultaneous edges", 1);
		apb_read(REG_TAG, word);
		t = word;
		check_word("simultaneous edges mask", 32'hA, 32'(t.mask));
		apb_write(REG_CTRL, 32'h0);
		check_bit("running after disable", 1'b0, running);
		detectors = 4'b0011;
		step();
		detectors = '0;
		repeat (8) step();   // well past the 3 cycle capture latency
		apb_read(REG_STATUS, word);
		check_word("disabled detection status", 32'h1, word);
	endtask

	task automatic test_overflow();
		logic [31:0] word;
		tag_t        t;
		tag_t        prev;
		tag_t        exp;
		apb_write(REG_CTRL, 32'h1);
		for (int i = 0; i < 20; i++) begin
			step();
			detectors = NUM_CHANNELS'(1 << (i % 3));   // channel period 3 keeps tag 0 and tag 4 apart
			step();
			detectors = '0;
			step();
		end
		repeat (6) step();
		apb_read(REG_STATUS, word);
		check_word("overflow status", 32'h1002, word);   // level 16 and overflow
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			apb_read(REG_TAG, word);
			t = word;
			if (i == 0) begin
				check_word("overflow tag 0 mask", 32'h1, 32'(t.mask));
			end else begin
				exp.mask = NUM_CHANNELS'(1 << (i % 3));
				exp.ts   = prev.ts + TS_WIDTH'(3);
				check_tag($sformatf("overflow tag %0d", i), exp, t);
			end
			prev = t;
		end
		apb_read(REG_TAG, word);
		check_word("read of empty FIFO", 32'h0, word);
		apb_read(REG_STATUS, word);
		check_word("status after drain", 32'h3, word);
		apb_write(REG_STATUS, 32'h2);
		apb_read(REG_STATUS, word);
		check_word("status after overflow clear", 32'h1, word);
		apb_write(REG_CTRL, 32'h0);
	endtask

	task automatic test_sequencer();
		apb_write(REG_SEQ_HIGH, 32'd3);
		apb_write(REG_SEQ_LOW, 32'd5);
		apb_write(REG_CTRL, 32'h52);   // mask 0101, seq_en
		check_seq_pattern("sequencer 3/5", 3, 5, 3);
		apb_write(REG_SEQ_HIGH, 32'd0);
		apb_write(REG_SEQ_LOW, 32'd0);
		repeat (20) step();
		check_seq_pattern("sequencer zero counts", 1, 1, 3);
		apb_write(REG_CTRL, 32'h50);
		step();
		@(negedge clk);
		for (int i = 0; i < 10; i++) begin
			check_word("laser_en after seq_en cleared", 32'h0, 32'(laser_en));
			@(negedge clk);
		end
	endtask

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		detectors = '0;
		void'($urandom(32'hea60b616));
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		test_reset_regs();
		test_tag_spacing();
		test_simultaneous_disable();
		test_overflow();
		test_sequencer();
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire
